/* axil_burst_master.f */
design/axil_burst_pkg.sv
design/axil_wdata_packer.sv
design/axil_burst_sequencer.sv
design/axil_rdata_collector.sv
design/axil_burst_master.sv
tb/axil_mem_slave.sv
tb/tb_axil_burst_master.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_axil_burst_master \
    -f axil_burst_master.f &&
./obj_dir/Vtb_axil_burst_master | tee /dev/stderr | grep -qx "TEST RESULT: PASS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* tb/tb_axil_burst_master.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axil_burst_master
    import axil_burst_pkg::*;
();

    localparam int WAIT_LIMIT = 2000;  // Cycles one command may take

    logic                  clk;
    logic                  rst;
    logic [7:0]            cmd;
    logic [31:0]           addr;
    logic [7:0]            write_data [BUF_BYTES];
    logic                  start;
    logic                  done;
    logic [7:0]            status;
    logic [7:0]            read_data [BUF_BYTES];
    logic [BYTE_IDX_W-1:0] read_count;
    logic [31:0]           awaddr, wdata, araddr, rdata;
    logic [2:0]            awprot, arprot;
    logic [3:0]            wstrb;
    logic [1:0]            bresp, rresp;
    logic                  awvalid, awready, wvalid, wready, bvalid, bready;
    logic                  arvalid, arready, rvalid, rready;
    logic [7:0]            model_mem [256];

    axil_burst_master #(.TIMEOUT_CYCLES(64)) dut0 (.*);
    axil_mem_slave slave0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [7:0] fill_byte(input int i);
        return 8'((i * 37) ^ 8'h5c);  // Slave's power-up contents
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Aligned start so the whole burst stays inside 0x000 to 0x0FF
    function automatic logic [31:0] pick_mem_addr(input logic [1:0] size, input logic [3:0] len,
                                                  input logic inc);
        int nb;
        int span;
        int base;

        nb   = 1 << size;
        span = inc ? nb * (int'(len) + 1) : nb;
        base = int'($urandom_range(256 - span, 0));
        return 32'(base - base % nb);
    endfunction

    task automatic run_burst(input logic [7:0] c, input logic [31:0] a);
        logic        rd;
        logic        inc;
        logic [1:0]  size;
        int          nb;
        int          beats;
        int          n;
        int          cycles;
        logic [31:0] baddr;
        logic [7:0]  exp_status;
        logic [7:0]  exp_rd [BUF_BYTES];
        logic        saw_valid;

        rd    = c[7];
        inc   = c[6];
        size  = c[5:4];
        beats = int'(c[3:0]) + 1;
        nb    = (size == 2'd0) ? 1 : (size == 2'd1) ? 2 : (size == 2'd2) ? 4 : 0;

        @(negedge clk);
        foreach (write_data[i]) write_data[i] = 8'($urandom);
        cmd   = c;
        addr  = a;
        start = 1'b1;

        // Expected outcome from the command alone
        n = 0;
        if ((nb == 0) || ((a % 32'(nb)) != 0)) begin
            exp_status = STATUS_ADDR_ALIGN;
        end else if (a >= 32'h200) begin
            exp_status = STATUS_TIMEOUT;
        end else if (a >= 32'h100) begin
            exp_status = STATUS_SLVERR;
            n = beats * nb;  // Every beat still runs
        end else begin
            exp_status = STATUS_OK;
            for (int i = 0; i < beats; i++) begin
                baddr = inc ? a + 32'(i * nb) : a;
                for (int k = 0; k < nb; k++) begin
                    if (rd) exp_rd[n] = model_mem[8'(baddr + 32'(k))];
                    else    model_mem[8'(baddr + 32'(k))] = write_data[i * nb + k];
                    n++;
                end
            end
        end

        saw_valid = 1'b0;
        cycles    = 0;
        @(negedge clk);
        start = 1'b0;
        while (!done) begin
            if (awvalid || arvalid) saw_valid = 1'b1;
            check("awprot", 32'(awprot), 32'd0);
            check("arprot", 32'(arprot), 32'd0);
            if (cycles == WAIT_LIMIT) begin
                $display("No done pulse within %0d cycles of start", WAIT_LIMIT);
                $display("TEST RESULT: FAIL");
                $fatal(1, "command %h at %h never finished", c, a);
            end
            cycles++;
            @(negedge clk);
        end

        check("status", 32'(status), 32'(exp_status));
        if (exp_status == STATUS_ADDR_ALIGN) check("address valid seen", 32'(saw_valid), 32'd0);
        if (rd) begin
            check("read_count", 32'(read_count), 32'(n));
            if (exp_status == STATUS_OK) begin
                for (int j = 0; j < n; j++) begin
                    check($sformatf("read_data[%0d]", j), 32'(read_data[j]), 32'(exp_rd[j]));
                end
            end
        end

        @(negedge clk);
        check("done", 32'(done), 32'd0);  // Pulse lasts one cycle
    endtask

    initial begin
        logic [1:0]  size;
        logic [3:0]  len;
        logic        inc;
        int unsigned seed_ret;

        seed_ret = $urandom(32'ha419_2584);
        rst   = 1'b1;
        start = 1'b0;
        cmd   = '0;
        addr  = '0;
        foreach (write_data[i]) write_data[i] = 8'h00;
        foreach (model_mem[i]) model_mem[i] = fill_byte(i);
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        repeat (12) begin  // Incrementing writes into memory
            size = 2'($urandom_range(2, 0));
            len  = 4'($urandom_range(15, 0));
            run_burst({1'b0, 1'b1, size, len}, pick_mem_addr(size, len, 1'b1));
        end
        for (int q = 0; q < 4; q++) run_burst(8'hef, 32'(q * 64));  // Full word sweep

        repeat (12) begin
            size = 2'($urandom_range(2, 0));
            len  = 4'($urandom_range(15, 0));
            inc  = 1'($urandom_range(1, 0));
            run_burst({1'b1, inc, size, len}, pick_mem_addr(size, len, inc));
        end

        // Misaligned starts and the invalid size
        run_burst({1'b0, 1'b1, 2'd1, 4'd3}, 32'h0000_0011);
        run_burst({1'b1, 1'b1, 2'd2, 4'd0}, 32'h0000_0042);
        run_burst({1'b1, 1'b0, 2'd3, 4'd5}, 32'h0000_0040);
        run_burst({1'b0, 1'b1, 2'd3, 4'd0}, 32'h0000_0000);

        run_burst({1'b0, 1'b1, 2'd2, 4'd7}, 32'h0000_0120);   // Error region
        run_burst({1'b1, 1'b1, 2'd1, 4'd15}, 32'h0000_0180);

        run_burst({1'b1, 1'b1, 2'd2, 4'd3}, 32'h0000_0200);   // Stall region
        run_burst({1'b0, 1'b1, 2'd0, 4'd2}, 32'h0000_0300);
        run_burst({1'b0, 1'b1, 2'd2, 4'd3}, 32'h0000_0010);   // Recovers afterwards

        repeat (6) begin  // Fixed address, last beat wins
            size = 2'($urandom_range(2, 0));
            len  = 4'($urandom_range(15, 0));
            run_burst({1'b0, 1'b0, size, len}, pick_mem_addr(size, len, 1'b0));
        end
        for (int q = 0; q < 4; q++) run_burst(8'hef, 32'(q * 64));

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/axil_mem_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_mem_slave (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);

    logic [7:0] mem [256];  // Backs 0x000 to 0x0FF
    logic [2:0] delay;      // Cycles left before ready
    logic       pending;
    logic [7:0] wbase;
    logic [7:0] rbase;

    assign wbase   = {awaddr[7:2], 2'b00};
    assign rbase   = {araddr[7:2], 2'b00};
    assign pending = (awvalid && !awready) || (wvalid && !wready) || (arvalid && !arready);

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'((i * 37) ^ 8'h5c);  // Depends on every address bit
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            bresp   <= 2'b00;
            rresp   <= 2'b00;
            rdata   <= '0;
            delay   <= '0;
        end else begin
            // Ready is a one-cycle pulse after 0 to 5 idle cycles
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            if (!pending) begin
                delay <= 3'($urandom_range(5, 0));
            end else if (delay != 3'd0) begin
                delay <= delay - 3'd1;
            end else if (awvalid && !awready) begin
                awready <= (awaddr < 32'h200);  // Stall region never answers
            end else if (arvalid && !arready) begin
                arready <= (araddr < 32'h200);
            end else begin
                wready <= 1'b1;
            end

            if (wvalid && wready) begin
                for (int i = 0; i < 4; i++) begin
                    if (wstrb[i] && (awaddr < 32'h100)) begin
                        mem[wbase + 8'(i)] <= wdata[8*i +: 8];
                    end
                end
                bresp  <= (awaddr < 32'h100) ? 2'b00 : 2'b10;  // SLVERR above memory
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end

            if (arvalid && arready) begin
                rdata  <= (araddr < 32'h100) ? {mem[rbase + 8'd3], mem[rbase + 8'd2],
                                                mem[rbase + 8'd1], mem[rbase]} : 32'h0;
                rresp  <= (araddr < 32'h100) ? 2'b00 : 2'b10;
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* design/axil_burst_master.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_burst_master
    import axil_burst_pkg::*;
#(
    parameter int TIMEOUT_CYCLES = 2500  // Cycles one channel wait may last
) (
    input  logic                  clk,
    input  logic                  rst,

    // Command side
    input  logic [7:0]            cmd,
    input  logic [31:0]           addr,
    input  logic [7:0]            write_data [BUF_BYTES],
    input  logic                  start,
    output logic                  done,
    output logic [7:0]            status,
    output logic [7:0]            read_data [BUF_BYTES],
    output logic [BYTE_IDX_W-1:0] read_count,

    // AXI4-Lite master
    output logic [31:0]           awaddr,
    output logic [2:0]            awprot,
    output logic                  awvalid,
    input  logic                  awready,
    output logic [31:0]           wdata,
    output logic [3:0]            wstrb,
    output logic                  wvalid,
    input  logic                  wready,
    input  logic [1:0]            bresp,
    input  logic                  bvalid,
    output logic                  bready,
    output logic [31:0]           araddr,
    output logic [2:0]            arprot,
    output logic                  arvalid,
    input  logic                  arready,
    input  logic [31:0]           rdata,
    input  logic [1:0]            rresp,
    input  logic                  rvalid,
    output logic                  rready
);

    cmd_word_u             cmd_in;
    cmd_word_u             cmd_q;
    logic [31:0]           cur_addr;
    logic [BYTE_IDX_W-1:0] byte_idx;
    logic                  read_clear;
    status_e               status_q;

    assign cmd_in.raw = cmd;
    assign status     = status_q;

    // Both address channels carry the current beat address
    assign awaddr = cur_addr;
    assign araddr = cur_addr;
    assign awprot = 3'b000;
    assign arprot = 3'b000;

    axil_burst_sequencer #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_seq (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd_in),
        .addr       (addr),
        .start      (start),
        .awready    (awready),
        .wready     (wready),
        .bvalid     (bvalid),
        .bresp      (bresp),
        .arready    (arready),
        .rvalid     (rvalid),
        .rresp      (rresp),
        .cmd_q      (cmd_q),
        .cur_addr   (cur_addr),
        .byte_idx   (byte_idx),
        .read_clear (read_clear),
        .awvalid    (awvalid),
        .wvalid     (wvalid),
        .bready     (bready),
        .arvalid    (arvalid),
        .rready     (rready),
        .done       (done),
        .status     (status_q)
    );

    axil_wdata_packer u_pack (
        .write_data (write_data),
        .cmd_q      (cmd_q),
        .addr_lo    (cur_addr[1:0]),
        .byte_idx   (byte_idx),
        .wdata      (wdata),
        .wstrb      (wstrb)
    );

    axil_rdata_collector u_coll (
        .clk        (clk),
        .rst        (rst),
        .clear      (read_clear),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .size       (cmd_q.f.size),
        .addr_lo    (cur_addr[1:0]),
        .read_data  (read_data),
        .read_count (read_count)
    );

endmodule

`default_nettype wire

/* design/axil_rdata_collector.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_rdata_collector
    import axil_burst_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clear,
    input  logic                  rvalid,
    input  logic                  rready,
    input  logic [31:0]           rdata,
    input  logic [1:0]            size,
    input  logic [1:0]            addr_lo,
    output logic [7:0]            read_data [BUF_BYTES],
    output logic [BYTE_IDX_W-1:0] read_count
);

    localparam int BASE_W = BYTE_IDX_W - 1;

    logic       r_hs;
    logic [2:0] n_bytes;

    assign r_hs    = rvalid && rready;
    assign n_bytes = beat_bytes(size);

    // Beat bytes appended at the current count, same lanes as the packer
    always_ff @(posedge clk) begin
        if (r_hs) begin
            for (int k = 0; k < 4; k++) begin
                if (k < int'(n_bytes)) begin
                    read_data[read_count[BASE_W-1:0] + BASE_W'(k)] <=
                        rdata[8*beat_lane(size, addr_lo, 2'(k)) +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            read_count <= '0;
        end else if (clear) begin
            read_count <= '0;
        end else if (r_hs) begin
            read_count <= read_count + BYTE_IDX_W'(n_bytes);
        end
    end

    // At most 16 word beats between clears
    a_count_max: assert property (@(posedge clk) disable iff (rst)
        read_count <= BYTE_IDX_W'(BUF_BYTES));

endmodule

`default_nettype wire

/* design/axil_burst_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_burst_sequencer
    import axil_burst_pkg::*;
#(
    parameter int TIMEOUT_CYCLES = 2500
) (
    input  logic                  clk,
    input  logic                  rst,
    input  cmd_word_u             cmd,
    input  logic [31:0]           addr,
    input  logic                  start,
    input  logic                  awready,
    input  logic                  wready,
    input  logic                  bvalid,
    input  logic [1:0]            bresp,
    input  logic                  arready,
    input  logic                  rvalid,
    input  logic [1:0]            rresp,
    output cmd_word_u             cmd_q,
    output logic [31:0]           cur_addr,
    output logic [BYTE_IDX_W-1:0] byte_idx,
    output logic                  read_clear,
    output logic                  awvalid,
    output logic                  wvalid,
    output logic                  bready,
    output logic                  arvalid,
    output logic                  rready,
    output logic                  done,
    output status_e               status
);

    localparam int TMO_W = $clog2(TIMEOUT_CYCLES + 1);

    typedef enum logic [3:0] {
        S_IDLE,
        S_CHECK,
        S_WR_ADDR,
        S_WR_DATA,
        S_WR_RESP,
        S_RD_ADDR,
        S_RD_DATA,
        S_STEP,
        S_FINISH
    } state_e;

    state_e           state;
    state_e           state_nxt;
    logic [3:0]       beat_cnt;
    logic [TMO_W-1:0] tmo_cnt;
    logic [2:0]       n_bytes;
    logic             start_ok;
    logic             aligned;
    logic             last_beat;
    logic             waiting;
    logic             any_hs;
    logic             tmo_hit;
    logic             aw_hs, w_hs, b_hs, ar_hs, r_hs;

    assign start_ok  = start && (state == S_IDLE);
    assign n_bytes   = beat_bytes(cmd_q.f.size);
    assign last_beat = (beat_cnt == cmd_q.f.len);

    // One channel active at a time, straight from the state
    assign awvalid = (state == S_WR_ADDR);
    assign wvalid  = (state == S_WR_DATA);
    assign bready  = (state == S_WR_RESP);
    assign arvalid = (state == S_RD_ADDR);
    assign rready  = (state == S_RD_DATA);
    assign done    = (state == S_FINISH);

    assign aw_hs  = awvalid && awready;
    assign w_hs   = wvalid && wready;
    assign b_hs   = bready && bvalid;
    assign ar_hs  = arvalid && arready;
    assign r_hs   = rready && rvalid;
    assign any_hs = aw_hs || w_hs || b_hs || ar_hs || r_hs;

    assign waiting = awvalid || wvalid || bready || arvalid || rready;
    // Last allowed wait cycle passed without a handshake
    assign tmo_hit = waiting && !any_hs && (tmo_cnt == TMO_W'(TIMEOUT_CYCLES - 1));

    always_comb begin
        case (cmd_q.f.size)
            2'd0:    aligned = 1'b1;
            2'd1:    aligned = !cur_addr[0];
            2'd2:    aligned = (cur_addr[1:0] == 2'b00);
            default: aligned = 1'b0;  // Size 3 never aligns
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (start) state_nxt = S_CHECK;
            end
            S_CHECK: begin
                if (!aligned)         state_nxt = S_FINISH;
                else if (cmd_q.f.rd)  state_nxt = S_RD_ADDR;
                else                  state_nxt = S_WR_ADDR;
            end
            S_WR_ADDR: begin
                if (aw_hs)        state_nxt = S_WR_DATA;
                else if (tmo_hit) state_nxt = S_FINISH;
            end
            S_WR_DATA: begin
                if (w_hs)         state_nxt = S_WR_RESP;
                else if (tmo_hit) state_nxt = S_FINISH;
            end
            S_WR_RESP: begin
                if (b_hs)         state_nxt = last_beat ? S_FINISH : S_STEP;
                else if (tmo_hit) state_nxt = S_FINISH;
            end
            S_RD_ADDR: begin
                if (ar_hs)        state_nxt = S_RD_DATA;
                else if (tmo_hit) state_nxt = S_FINISH;
            end
            S_RD_DATA: begin
                if (r_hs)         state_nxt = last_beat ? S_FINISH : S_STEP;
                else if (tmo_hit) state_nxt = S_FINISH;
            end
            S_STEP: begin
                state_nxt = cmd_q.f.rd ? S_RD_ADDR : S_WR_ADDR;
            end
            default: state_nxt = S_IDLE;  // S_FINISH
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            cmd_q      <= '0;
            beat_cnt   <= '0;
            tmo_cnt    <= '0;
            status     <= STATUS_OK;
            read_clear <= 1'b0;
        end else begin
            state      <= state_nxt;
            read_clear <= start_ok;

            // Wait counter restarts on every state change
            if (!waiting || (state_nxt != state)) tmo_cnt <= '0;
            else                                   tmo_cnt <= tmo_cnt + 1'b1;

            if (start_ok) begin
                cmd_q    <= cmd;
                beat_cnt <= '0;
                status   <= STATUS_OK;
            end
            if (state == S_STEP) beat_cnt <= beat_cnt + 1'b1;

            if ((state == S_CHECK) && !aligned) status <= STATUS_ADDR_ALIGN;
            // Slave error is recorded, the burst goes on
            if ((b_hs && (bresp != 2'b00)) || (r_hs && (rresp != 2'b00))) begin
                status <= STATUS_SLVERR;
            end
            if (tmo_hit) status <= STATUS_TIMEOUT;
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            cur_addr <= addr;
            byte_idx <= '0;
        end else if (state == S_STEP) begin
            byte_idx <= byte_idx + BYTE_IDX_W'(n_bytes);
            if (cmd_q.f.inc) cur_addr <= cur_addr + 32'(n_bytes);  // Fixed mode keeps the address
        end
    end

    a_one_addr_valid: assert property (@(posedge clk) disable iff (rst)
        !(awvalid && arvalid));

    // Address valids hold until accepted or timed out
    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready && !tmo_hit |=> awvalid);
    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready && !tmo_hit |=> arvalid);

endmodule

`default_nettype wire

/* design/axil_wdata_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_wdata_packer
    import axil_burst_pkg::*;
(
    input  logic [7:0]            write_data [BUF_BYTES],
    input  cmd_word_u             cmd_q,
    input  logic [1:0]            addr_lo,
    input  logic [BYTE_IDX_W-1:0] byte_idx,
    output logic [31:0]           wdata,
    output logic [3:0]            wstrb
);

    localparam int BASE_W = BYTE_IDX_W - 1;  // Index into the 64-byte buffer

    logic [2:0] n_bytes;

    assign n_bytes = beat_bytes(cmd_q.f.size);

    // Byte k of the beat goes to its lane, taken in buffer order
    always_comb begin
        logic [1:0]        lane;
        logic [BASE_W-1:0] src;

        wdata = '0;
        wstrb = '0;
        for (int k = 0; k < 4; k++) begin
            lane = beat_lane(cmd_q.f.size, addr_lo, 2'(k));
            src  = byte_idx[BASE_W-1:0] + BASE_W'(k);
            if (k < int'(n_bytes)) begin
                wdata[8*lane +: 8] = write_data[src];
                wstrb[lane]        = 1'b1;
            end
        end

        // Every legal size drives at least one lane
        if (cmd_q.f.size != 2'd3) begin
            a_strb_nonzero: assert (wstrb != 4'd0)
                else $error("wstrb empty for size %0d", cmd_q.f.size);
        end
    end

endmodule

`default_nettype wire

/* design/axil_burst_pkg.sv */
`default_nettype none

package axil_burst_pkg;

    localparam int BUF_BYTES  = 64;  // 16 beats of 4 bytes
    localparam int BYTE_IDX_W = 7;   // Holds a full count of 64

    // Command byte, fields view
    typedef struct packed {
        logic       rd;    // 1 = read
        logic       inc;   // Incrementing address
        logic [1:0] size;  // 0 byte, 1 half word, 2 word, 3 invalid
        logic [3:0] len;   // Beats minus one
    } cmd_fields_t;

    typedef union packed {
        logic [7:0]  raw;  // As it arrives on the command port
        cmd_fields_t f;
    } cmd_word_u;

    typedef enum logic [7:0] {
        STATUS_OK         = 8'h00,
        STATUS_ADDR_ALIGN = 8'h03,
        STATUS_TIMEOUT    = 8'h04,
        STATUS_SLVERR     = 8'h05
    } status_e;

    // Bytes moved per beat, zero for the invalid size
    function automatic logic [2:0] beat_bytes(input logic [1:0] size);
        case (size)
            2'd0:    return 3'd1;
            2'd1:    return 3'd2;
            2'd2:    return 3'd4;
            default: return 3'd0;
        endcase
    endfunction

    // Lane carrying byte k of a beat
    function automatic logic [1:0] beat_lane(input logic [1:0] size, input logic [1:0] addr_lo,
                                             input logic [1:0] k);
        case (size)
            2'd0:    return addr_lo;
            2'd1:    return {addr_lo[1], 1'b0} + k;  // Lower or upper half
            default: return k;
        endcase
    endfunction

endpackage

`default_nettype wire
